/* rvCorePkg.sv */
package rvCorePkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////
    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0]             word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] regAddr_t;

    // RV32I opcodes kept in this core
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    localparam word_t NOP_INSTR = 32'h0000_0013; // addi x0,x0,0

    typedef enum logic [3:0] {
        ALU_AND = 4'b0000,
        ALU_OR  = 4'b0110,
        ALU_ADD = 4'b0010,
        ALU_SLL = 4'b0001,
        ALU_SRL = 4'b0101,
        ALU_SRA = 4'b1101,
        ALU_SUB = 4'b1000
    } aluOp_e;

    typedef enum logic [1:0] {
        FWD_REG   = 2'b00,
        FWD_MEMWB = 2'b01,
        FWD_EXMEM = 2'b10
    } fwdSel_e;

    ////////////////////////////////////////////////////////////
    // Stage payloads
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   isBranch;
        logic   isJump;
        logic   aluSrc;   // Immediate as operand B
        aluOp_e aluOp;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } ifId_t;

    typedef struct packed {
        logic       valid;
        ctrl_t      ctrl;
        word_t      pc;
        word_t      rs1Data;
        word_t      rs2Data;
        regAddr_t   rs1Addr;
        regAddr_t   rs2Addr;
        word_t      imm;
        regAddr_t   rd;
        logic [2:0] funct3;
    } idEx_t;

    typedef struct packed {
        logic     valid;
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
        word_t    result;
        word_t    storeData;
        regAddr_t rd;
    } exMem_t;

    typedef struct packed {
        logic     valid;
        logic     regWrite;
        logic     memRead;
        word_t    result;
        word_t    loadData;
        regAddr_t rd;
    } memWb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } memReq_t;

endpackage

/* pipeStageReg.sv */
`timescale 1ns/1ps

module pipeStageReg #(
    parameter type T = logic
) (
    input  logic clock,
    input  logic i_arstN,
    input  logic i_hold,
    input  logic i_flush,
    input  T     i_d,
    output T     o_q
);

    // All-zero payload is a bubble
    always_ff @(posedge clock or negedge i_arstN) begin
        if (!i_arstN) begin
            o_q <= '0;
        end else if (i_flush) begin
            o_q <= '0;
        end else if (!i_hold) begin
            o_q <= i_d;
        end
    end

endmodule

/* fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit import rvCorePkg::*; (
    input  logic      clock,
    input  logic      i_arstN,
    input  redirect_t i_redirect,
    input  logic      i_pcHold,
    input  logic      i_fetchGrant,
    input  word_t     i_instr,
    output word_t     o_fetchAddr,
    output ifId_t     o_ifId
);

    word_t pc;
    word_t nextPc;

    // Redirect beats both hold and a denied grant
    always_comb begin
        if (i_redirect.taken) begin
            nextPc = i_redirect.target;
        end else if (i_pcHold || !i_fetchGrant) begin
            nextPc = pc;
        end else begin
            nextPc = pc + word_t'(4);
        end
    end

    always_ff @(posedge clock or negedge i_arstN) begin
        if (!i_arstN) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    assign o_fetchAddr  = pc;
    assign o_ifId.valid = i_fetchGrant;
    assign o_ifId.pc    = pc;
    assign o_ifId.instr = i_fetchGrant ? i_instr : NOP_INSTR; // Port busy with data
endmodule

/* decodeUnit.sv */
`timescale 1ns/1ps

module decodeUnit import rvCorePkg::*; (
    input  ifId_t    i_ifId,
    input  word_t    i_rs1Data,
    input  word_t    i_rs2Data,
    output regAddr_t o_rs1Addr,
    output regAddr_t o_rs2Addr,
    output idEx_t    o_idEx
);

    word_t      instr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    ctrl_t      ctrl;
    word_t      imm;

    // Bit 30 selects sub or sra
    function automatic aluOp_e aluFromFunct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    assign instr     = i_ifId.instr;
    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign o_rs1Addr = instr[19:15];
    assign o_rs2Addr = instr[24:20];

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (opcode)
            OP_LOAD: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = ALU_ADD;
                imm           = {{20{instr[31]}}, instr[31:20]};
            end
            OP_IMM: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = aluFromFunct(funct3, instr[30] && funct3 == 3'b101);
                imm           = {{20{instr[31]}}, instr[31:20]};
            end
            OP_STORE: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = ALU_ADD;
                imm           = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OP_BRANCH: begin
                ctrl.isBranch = 1'b1;
                ctrl.aluOp    = ALU_SUB;
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            OP_JAL: begin
                ctrl.regWrite = 1'b1;
                ctrl.isJump   = 1'b1;
                ctrl.aluOp    = ALU_ADD;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            OP_REG: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluFromFunct(funct3, instr[30]);
            end
            default: ctrl = '0; // Unknown opcode does nothing
        endcase
    end

    always_comb begin
        o_idEx = '0;
        if (i_ifId.valid) begin
            o_idEx.valid   = 1'b1;
            o_idEx.ctrl    = ctrl;
            o_idEx.pc      = i_ifId.pc;
            o_idEx.rs1Data = i_rs1Data;
            o_idEx.rs2Data = i_rs2Data;
            o_idEx.rs1Addr = o_rs1Addr;
            o_idEx.rs2Addr = o_rs2Addr;
            o_idEx.imm     = imm;
            o_idEx.rd      = instr[11:7];
            o_idEx.funct3  = funct3;
        end
    end

endmodule

/* registerFile.sv */
`timescale 1ns/1ps

module registerFile import rvCorePkg::*; (
    input  logic     clock,
    input  logic     i_arstN,
    input  regAddr_t i_rs1Addr,
    input  regAddr_t i_rs2Addr,
    output word_t    o_rs1Data,
    output word_t    o_rs2Data,
    input  memWb_t   i_memWb,
    output word_t    o_wbData
);

    word_t regs [NUM_REGS];
    logic  wrEn;

    assign o_wbData = i_memWb.memRead ? i_memWb.loadData : i_memWb.result;
    assign wrEn     = i_memWb.valid && i_memWb.regWrite && (i_memWb.rd != '0);

    always_ff @(posedge clock or negedge i_arstN) begin
        if (!i_arstN) begin
            regs <= '{default: '0};
        end else if (wrEn) begin
            regs[i_memWb.rd] <= o_wbData;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read ports, bypass the write of this cycle
    ////////////////////////////////////////////////////////////
    assign o_rs1Data = (i_rs1Addr == '0) ? '0 :
                       (wrEn && i_memWb.rd == i_rs1Addr) ? o_wbData : regs[i_rs1Addr];
    assign o_rs2Data = (i_rs2Addr == '0) ? '0 :
                       (wrEn && i_memWb.rd == i_rs2Addr) ? o_wbData : regs[i_rs2Addr];

endmodule

/* executeUnit.sv */
`timescale 1ns/1ps

module executeUnit import rvCorePkg::*; (
    input  idEx_t     i_idEx,
    input  fwdSel_e   i_fwdA,
    input  fwdSel_e   i_fwdB,
    input  word_t     i_exMemResult,
    input  word_t     i_wbData,
    output exMem_t    o_exMem,
    output redirect_t o_redirect
);

    word_t opA;
    word_t opB;
    word_t aluB;
    word_t aluOut;
    word_t pcPlus4;
    logic  brCond;

    function automatic word_t fwdMux(input fwdSel_e sel, input word_t regVal,
                                     input word_t exMemVal, input word_t wbVal);
        case (sel)
            FWD_EXMEM: return exMemVal;
            FWD_MEMWB: return wbVal;
            default:   return regVal;
        endcase
    endfunction

    assign opA     = fwdMux(i_fwdA, i_idEx.rs1Data, i_exMemResult, i_wbData);
    assign opB     = fwdMux(i_fwdB, i_idEx.rs2Data, i_exMemResult, i_wbData);
    assign aluB    = i_idEx.ctrl.aluSrc ? i_idEx.imm : opB;
    assign pcPlus4 = i_idEx.pc + word_t'(4);

    always_comb begin
        case (i_idEx.ctrl.aluOp)
            ALU_AND: aluOut = opA & aluB;
            ALU_OR:  aluOut = opA | aluB;
            ALU_ADD: aluOut = opA + aluB;
            ALU_SUB: aluOut = opA - aluB;
            ALU_SLL: aluOut = opA << aluB[4:0];
            ALU_SRL: aluOut = opA >> aluB[4:0];
            ALU_SRA: aluOut = word_t'($signed(opA) >>> aluB[4:0]);
            default: aluOut = '0;
        endcase
    end

    // Branch condition from funct3
    always_comb begin
        case (i_idEx.funct3)
            3'b000:  brCond = (opA == opB);
            3'b001:  brCond = (opA != opB);
            3'b100:  brCond = ($signed(opA) < $signed(opB));
            3'b101:  brCond = ($signed(opA) >= $signed(opB));
            default: brCond = 1'b0;
        endcase
    end

    assign o_redirect.taken  = i_idEx.valid &&
                               (i_idEx.ctrl.isJump || (i_idEx.ctrl.isBranch && brCond));
    assign o_redirect.target = i_idEx.pc + i_idEx.imm;

    assign o_exMem.valid     = i_idEx.valid;
    assign o_exMem.regWrite  = i_idEx.ctrl.regWrite;
    assign o_exMem.memRead   = i_idEx.ctrl.memRead;
    assign o_exMem.memWrite  = i_idEx.ctrl.memWrite;
    assign o_exMem.result    = i_idEx.ctrl.isJump ? pcPlus4 : aluOut; // Link value for jal
    assign o_exMem.storeData = opB;
    assign o_exMem.rd        = i_idEx.rd;

endmodule

/* memoryPort.sv */
`timescale 1ns/1ps

module memoryPort import rvCorePkg::*; (
    input  word_t   i_fetchAddr,
    input  exMem_t  i_exMem,
    input  word_t   i_memRdata,
    output memReq_t o_memReq,
    output logic    o_fetchGrant,
    output word_t   o_instr,
    output memWb_t  o_memWb
);

    logic dataAccess;

    // Loads and stores take the port ahead of fetch
    assign dataAccess     = i_exMem.valid && (i_exMem.memRead || i_exMem.memWrite);
    assign o_fetchGrant   = !dataAccess;

    assign o_memReq.addr  = dataAccess ? i_exMem.result : i_fetchAddr;
    assign o_memReq.wdata = i_exMem.storeData;
    assign o_memReq.we    = dataAccess && i_exMem.memWrite;

    assign o_instr = i_memRdata;

    assign o_memWb.valid    = i_exMem.valid;
    assign o_memWb.regWrite = i_exMem.regWrite;
    assign o_memWb.memRead  = i_exMem.memRead;
    assign o_memWb.result   = i_exMem.result;
    assign o_memWb.loadData = i_memRdata; // Only meaningful for loads
    assign o_memWb.rd       = i_exMem.rd;

endmodule

/* hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit import rvCorePkg::*; (
    input  ifId_t     i_ifId,
    input  idEx_t     i_idEx,
    input  exMem_t    i_exMem,
    input  memWb_t    i_memWb,
    input  redirect_t i_redirect,
    output logic      o_pcHold,
    output logic      o_ifIdHold,
    output logic      o_ifIdFlush,
    output logic      o_idExFlush,
    output fwdSel_e   o_fwdA,
    output fwdSel_e   o_fwdB
);

    logic [6:0] opcode;
    logic       usesRs1;
    logic       usesRs2;
    logic       loadUse;

    // EX/MEM loads are never forwarded, load-use covers them
    function automatic fwdSel_e pickFwd(input regAddr_t src, input exMem_t exMem,
                                        input memWb_t memWb);
        if (exMem.valid && exMem.regWrite && !exMem.memRead && exMem.rd != '0 &&
            exMem.rd == src) begin
            return FWD_EXMEM;
        end else if (memWb.valid && memWb.regWrite && memWb.rd != '0 && memWb.rd == src) begin
            return FWD_MEMWB;
        end
        return FWD_REG;
    endfunction

    assign opcode  = i_ifId.instr[6:0];
    assign usesRs1 = (opcode != OP_JAL);
    assign usesRs2 = (opcode == OP_REG) || (opcode == OP_STORE) || (opcode == OP_BRANCH);

    assign loadUse = i_idEx.valid && i_idEx.ctrl.memRead && i_idEx.rd != '0 && i_ifId.valid &&
                     ((usesRs1 && i_ifId.instr[19:15] == i_idEx.rd) ||
                      (usesRs2 && i_ifId.instr[24:20] == i_idEx.rd));

    assign o_pcHold    = loadUse;
    assign o_ifIdHold  = loadUse;
    assign o_ifIdFlush = i_redirect.taken;
    assign o_idExFlush = i_redirect.taken || loadUse; // Bubble into execute

    assign o_fwdA = pickFwd(i_idEx.rs1Addr, i_exMem, i_memWb);
    assign o_fwdB = pickFwd(i_idEx.rs2Addr, i_exMem, i_memWb);

endmodule

/* rvCore.sv */
`timescale 1ns/1ps

module rvCore import rvCorePkg::*; (
    input  logic    clock,
    input  logic    i_arstN,
    output memReq_t o_memReq,
    input  word_t   i_memRdata
);

    word_t     fetchAddr;
    logic      fetchGrant;
    word_t     instr;
    ifId_t     ifIdD;
    ifId_t     ifIdQ;
    regAddr_t  rs1Addr;
    regAddr_t  rs2Addr;
    word_t     rs1Data;
    word_t     rs2Data;
    idEx_t     idExD;
    idEx_t     idExQ;
    exMem_t    exMemD;
    exMem_t    exMemQ;
    memWb_t    memWbD;
    memWb_t    memWbQ;
    word_t     wbData;
    redirect_t redirect;
    logic      pcHold;
    logic      ifIdHold;
    logic      ifIdFlush;
    logic      idExFlush;
    fwdSel_e   fwdA;
    fwdSel_e   fwdB;

    ////////////////////////////////////////////////////////////
    // Fetch and decode
    ////////////////////////////////////////////////////////////
    fetchUnit fetch_i (
        .clock        (clock),
        .i_arstN      (i_arstN),
        .i_redirect   (redirect),
        .i_pcHold     (pcHold),
        .i_fetchGrant (fetchGrant),
        .i_instr      (instr),
        .o_fetchAddr  (fetchAddr),
        .o_ifId       (ifIdD)
    );

    pipeStageReg #(.T(ifId_t)) ifIdReg_i (
        .clock   (clock),
        .i_arstN (i_arstN),
        .i_hold  (ifIdHold),
        .i_flush (ifIdFlush),
        .i_d     (ifIdD),
        .o_q     (ifIdQ)
    );

    decodeUnit decode_i (
        .i_ifId    (ifIdQ),
        .i_rs1Data (rs1Data),
        .i_rs2Data (rs2Data),
        .o_rs1Addr (rs1Addr),
        .o_rs2Addr (rs2Addr),
        .o_idEx    (idExD)
    );

    registerFile regFile_i (
        .clock     (clock),
        .i_arstN   (i_arstN),
        .i_rs1Addr (rs1Addr),
        .i_rs2Addr (rs2Addr),
        .o_rs1Data (rs1Data),
        .o_rs2Data (rs2Data),
        .i_memWb   (memWbQ),
        .o_wbData  (wbData)
    );

    pipeStageReg #(.T(idEx_t)) idExReg_i (
        .clock   (clock),
        .i_arstN (i_arstN),
        .i_hold  (1'b0),
        .i_flush (idExFlush),
        .i_d     (idExD),
        .o_q     (idExQ)
    );

    ////////////////////////////////////////////////////////////
    // Execute, memory and hazards
    ////////////////////////////////////////////////////////////
    executeUnit execute_i (
        .i_idEx        (idExQ),
        .i_fwdA        (fwdA),
        .i_fwdB        (fwdB),
        .i_exMemResult (exMemQ.result),
        .i_wbData      (wbData),
        .o_exMem       (exMemD),
        .o_redirect    (redirect)
    );

    pipeStageReg #(.T(exMem_t)) exMemReg_i (
        .clock   (clock),
        .i_arstN (i_arstN),
        .i_hold  (1'b0),
        .i_flush (1'b0),
        .i_d     (exMemD),
        .o_q     (exMemQ)
    );

    memoryPort memPort_i (
        .i_fetchAddr  (fetchAddr),
        .i_exMem      (exMemQ),
        .i_memRdata   (i_memRdata),
        .o_memReq     (o_memReq),
        .o_fetchGrant (fetchGrant),
        .o_instr      (instr),
        .o_memWb      (memWbD)
    );

    pipeStageReg #(.T(memWb_t)) memWbReg_i (
        .clock   (clock),
        .i_arstN (i_arstN),
        .i_hold  (1'b0),
        .i_flush (1'b0),
        .i_d     (memWbD),
        .o_q     (memWbQ)
    );

    hazardUnit hazard_i (
        .i_ifId      (ifIdQ),
        .i_idEx      (idExQ),
        .i_exMem     (exMemQ),
        .i_memWb     (memWbQ),
        .i_redirect  (redirect),
        .o_pcHold    (pcHold),
        .o_ifIdHold  (ifIdHold),
        .o_ifIdFlush (ifIdFlush),
        .o_idExFlush (idExFlush),
        .o_fwdA      (fwdA),
        .o_fwdB      (fwdB)
    );

endmodule

/* rvCore_asserts.sv */
`timescale 1ns/1ps

module rvCore_asserts import rvCorePkg::*; (
    input logic    clock,
    input logic    i_arstN,
    input memReq_t o_memReq
);

    localparam word_t DATA_BASE = 32'h0000_0400;
    localparam word_t DATA_END  = 32'h0000_0480; // One past the data region

    weKnown: assert property (@(posedge clock) disable iff (!i_arstN)
        !$isunknown(o_memReq.we))
        else $error("Write strobe is unknown");

    ////////////////////////////////////////////////////////////
    // Stores stay inside the data region
    ////////////////////////////////////////////////////////////
    storeInRegion: assert property (@(posedge clock) disable iff (!i_arstN)
        o_memReq.we |-> (o_memReq.addr[1:0] == 2'b00 &&
                         o_memReq.addr >= DATA_BASE && o_memReq.addr < DATA_END))
        else $error("Store address 0x%08h misaligned or outside data", o_memReq.addr);

    weLowInReset: assert property (@(posedge clock) !i_arstN |-> !o_memReq.we)
        else $error("Write strobe high during reset");

endmodule

bind rvCore rvCore_asserts asserts_i (
    .clock    (clock),
    .i_arstN  (i_arstN),
    .o_memReq (o_memReq)
);

/* tb_rvCore.sv */
`timescale 1ns/1ps

module tb_rvCore import rvCorePkg::*; ();

    localparam int    MEM_WORDS    = 512;
    localparam int    RAND_INSTR   = 52;
    localparam int    RESET_CYCLES = 8;
    localparam int    STORE_WAIT   = 2000;
    localparam int    QUIET_CYCLES = 40;
    localparam int    MODEL_STEPS  = 1000;
    localparam word_t DATA_BASE    = 32'h0000_0400;
    localparam word_t FINAL_BASE   = 32'h0000_0440;

    logic    clock;
    logic    arstN;
    memReq_t memReq;
    word_t   memRdata;
    word_t   mem [MEM_WORDS];
    word_t   refMem [MEM_WORDS];   // Program image, then the ISA model's memory
    word_t   lfsrState;
    memReq_t expStores [$];
    int      storeCount;
    int      expCount;
    int      cyc;
    int      i;

    rvCore dut_i (
        .clock      (clock),
        .i_arstN    (arstN),
        .o_memReq   (memReq),
        .i_memRdata (memRdata)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Unified memory, read in the same cycle
    assign memRdata = mem[memReq.addr[10:2]];

    always @(posedge clock) begin
        if (memReq.we) begin
            mem[memReq.addr[10:2]] <= memReq.wdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // Reporting and compares
    ////////////////////////////////////////////////////////////
    task automatic reportFailure(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic compareBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            reportFailure($sformatf("Fail %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic compareWord(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            reportFailure($sformatf("Fail %s: got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic compareMemReq(input string name, input memReq_t got, input memReq_t exp);
        if (got.addr !== exp.addr || got.wdata !== exp.wdata) begin
            reportFailure($sformatf("Fail %s: got addr 0x%08h data 0x%08h, %s 0x%08h data 0x%08h",
                                    name, got.addr, got.wdata, "expected addr",
                                    exp.addr, exp.wdata));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Random source and encoders
    ////////////////////////////////////////////////////////////
    function automatic word_t lfsrNext(input word_t s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // x^32+x^22+x^2+x+1
    endfunction

    function automatic word_t randBits(input int nBits);
        word_t v;
        int    b;
        v = '0;
        for (b = 0; b < nBits; b++) begin
            v         = {v[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
        return v;
    endfunction

    function automatic regAddr_t randReg();
        return regAddr_t'(1 + randBits(3) % 7); // x1 to x7
    endfunction

    function automatic word_t signExt(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // Index order add, sub, sll, srl, sra, or, and
    function automatic word_t regOp(input int sel, input regAddr_t rd, input regAddr_t rs1,
                                    input regAddr_t rs2);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = (sel == 1 || sel == 4) ? 7'h20 : 7'h00;
        case (sel)
            0, 1:    f3 = 3'b000;
            2:       f3 = 3'b001;
            3, 4:    f3 = 3'b101;
            5:       f3 = 3'b110;
            default: f3 = 3'b111;
        endcase
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    // Index order addi, andi, slli, srli
    function automatic word_t immOp(input int sel, input regAddr_t rd, input regAddr_t rs1);
        logic [11:0] imm;
        logic [2:0]  f3;
        imm = 12'(randBits(12));
        case (sel)
            0:       f3 = 3'b000;
            1:       f3 = 3'b111;
            2:       f3 = 3'b001;
            default: f3 = 3'b101;
        endcase
        if (sel >= 2) begin
            imm = {7'd0, imm[4:0]}; // Shift amount only
        end
        return {imm, rs1, f3, rd, OP_IMM};
    endfunction

    function automatic word_t loadWord(input logic [11:0] off, input regAddr_t rd);
        return {off, 5'd0, 3'b010, rd, OP_LOAD};
    endfunction

    function automatic word_t storeWord(input logic [11:0] off, input regAddr_t rs2);
        return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], OP_STORE};
    endfunction

    // Index order beq, bne, blt, bge
    function automatic word_t branchOp(input int sel, input regAddr_t rs1, input regAddr_t rs2,
                                       input logic [12:0] off);
        logic [2:0] f3;
        f3 = (sel < 2) ? 3'(sel) : 3'(sel + 2);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic word_t jalOp(input logic [20:0] off, input regAddr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    ////////////////////////////////////////////////////////////
    // Program generation
    ////////////////////////////////////////////////////////////
    task automatic buildProgram();
        int          idx;
        int          kind;
        int          skip;
        int          k;
        regAddr_t    rd;
        regAddr_t    rs1;
        regAddr_t    rs2;
        logic [11:0] off;
        for (k = 0; k < MEM_WORDS; k++) begin
            refMem[k] = word_t'(k) * 32'h9E37_79B9 + 32'h1357_0000;
        end
        idx = 0;
        while (idx < RAND_INSTR) begin
            kind = randBits(3);
            rd   = randReg();
            rs1  = randReg();
            rs2  = randReg();
            skip = 2 + randBits(2) % 3;
            off  = 12'(DATA_BASE + 4 * randBits(4));
            if (kind >= 5 && idx + 4 > RAND_INSTR) begin
                kind = 0; // No room left to jump over
            end
            case (kind)
                0, 1: refMem[idx] = regOp(randBits(3) % 7, rd, rs1, rs2);
                2:    refMem[idx] = immOp(randBits(2), rd, rs1);
                3:    refMem[idx] = loadWord(off, rd);
                4:    refMem[idx] = storeWord(off, rs2);
                5: begin
                    // Store, reload and use back to back
                    refMem[idx]     = storeWord(off, rs2);
                    refMem[idx + 1] = loadWord(off, rd);
                    refMem[idx + 2] = regOp(0, randReg(), rd, rs1);
                    idx += 2;
                end
                6:       refMem[idx] = branchOp(randBits(2), rs1, rs2, 13'(4 * skip));
                default: refMem[idx] = jalOp(21'(4 * skip), rd);
            endcase
            idx++;
        end
        for (k = 1; k < 8; k++) begin
            refMem[RAND_INSTR + k - 1] = storeWord(12'(FINAL_BASE + 4 * (k - 1)), regAddr_t'(k));
        end
        refMem[RAND_INSTR + 7] = jalOp('0, '0); // Parks the core
    endtask

    ////////////////////////////////////////////////////////////
    // ISA model
    ////////////////////////////////////////////////////////////
    function automatic word_t refAlu(input logic [2:0] f3, input logic alt, input word_t a,
                                     input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return '0;
        endcase
    endfunction

    task automatic runModel();
        word_t      regs [NUM_REGS];
        word_t      pc;
        word_t      nextPc;
        word_t      instr;
        word_t      a;
        word_t      b;
        word_t      addr;
        word_t      val;
        logic [2:0] f3;
        logic       wr;
        logic       taken;
        logic       parked;
        memReq_t    st;
        int         step;
        regs   = '{default: '0};
        pc     = '0;
        parked = 1'b0;
        for (step = 0; step < MODEL_STEPS && !parked; step++) begin
            instr  = refMem[pc[10:2]];
            f3     = instr[14:12];
            a      = regs[instr[19:15]];
            b      = regs[instr[24:20]];
            nextPc = pc + 32'd4;
            wr     = 1'b1;
            val    = '0;
            case (instr[6:0])
                OP_REG: val = refAlu(f3, instr[30], a, b);
                OP_IMM: val = refAlu(f3, instr[30] && f3 == 3'b101, a, signExt(instr[31:20]));
                OP_LOAD: begin
                    addr = a + signExt(instr[31:20]);
                    val  = refMem[addr[10:2]];
                end
                OP_STORE: begin
                    wr       = 1'b0;
                    addr     = a + signExt({instr[31:25], instr[11:7]});
                    refMem[addr[10:2]] = b;
                    st.addr  = addr;
                    st.wdata = b;
                    st.we    = 1'b1;
                    expStores.push_back(st);
                end
                OP_BRANCH: begin
                    wr = 1'b0;
                    case (f3)
                        3'b000:  taken = (a == b);
                        3'b001:  taken = (a != b);
                        3'b100:  taken = ($signed(a) < $signed(b));
                        default: taken = ($signed(a) >= $signed(b));
                    endcase
                    if (taken) begin
                        nextPc = pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                    end
                end
                OP_JAL: begin
                    val    = pc + 32'd4;
                    nextPc = pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
                    parked = (nextPc == pc);
                end
                default: wr = 1'b0;
            endcase
            if (wr && instr[11:7] != 5'd0) begin
                regs[instr[11:7]] = val;
            end
            pc = nextPc;
        end
        if (!parked) begin
            reportFailure("ISA model never reached the final self jump");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Store monitor and main sequence
    ////////////////////////////////////////////////////////////
    always @(negedge clock) begin
        if (arstN) begin
            if ($isunknown(memReq.we)) begin
                reportFailure("Write strobe went unknown after reset");
            end else if (memReq.we) begin
                if (storeCount < expCount) begin
                    compareMemReq("o_memReq", memReq, expStores[storeCount]);
                    storeCount++;
                end else begin
                    reportFailure("A store appeared that the model does not make");
                end
            end
        end
    end

    initial begin
        arstN      = 1'b0;
        storeCount = 0;
        expCount   = 0;
        lfsrState  = word_t'(62);
        buildProgram();
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] <= refMem[i];
        end
        runModel();
        expCount = expStores.size();
        for (cyc = 0; cyc < RESET_CYCLES; cyc++) begin
            @(negedge clock);
            compareBit("o_memReq.we", memReq.we, 1'b0);
        end
        @(posedge clock);
        arstN <= 1'b1;
        @(negedge clock);
        compareWord("o_memReq.addr", memReq.addr, '0); // First fetch
        for (cyc = 0; cyc < STORE_WAIT && storeCount < expCount; cyc++) begin
            @(posedge clock);
        end
        if (storeCount < expCount) begin
            reportFailure($sformatf("Timed out with %0d of %0d expected stores seen",
                                    storeCount, expCount));
        end else begin
            // Parked core, any late store is an extra one
            for (cyc = 0; cyc < QUIET_CYCLES; cyc++) begin
                @(posedge clock);
            end
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

/* src.f */
rvCorePkg.sv
pipeStageReg.sv
fetchUnit.sv
decodeUnit.sv
registerFile.sv
executeUnit.sv
memoryPort.sv
hazardUnit.sv
rvCore.sv
rvCore_asserts.sv
tb_rvCore.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - rvCorePkg.sv
  - pipeStageReg.sv
  - fetchUnit.sv
  - decodeUnit.sv
  - registerFile.sv
  - executeUnit.sv
  - memoryPort.sv
  - hazardUnit.sv
  - rvCore.sv
  - target: test
    files:
      - rvCore_asserts.sv
      - tb_rvCore.sv
